//--- include/zport_consts.svh
// port low bytes, xxBF bit positions and reset values of the port block
// included by the port modules and by the testbench
`ifndef ZPORT_CONSTS_SVH
`define ZPORT_CONSTS_SVH

// port low address bytes
`define PORT_FE      8'hFE // keys, tape, border, beeper
`define PORT_F6      8'hF6 // mirror of FE
`define PORT_FC      8'hFC // paging and border, no beeper
`define PORT_FD      8'hFD // 7FFD paging
`define PORT_F7      8'hF7 // EFF7 and the rest of xxF7
`define PORT_KJOY    8'h1F // kempston joystick, only outside shadow
`define PORT_KMOUSE  8'hDF // kempston mouse
`define PORT_BF      8'hBF // config register
`define PORT_ULAPLUS 8'h3B // ulaplus select/data

// xxBF bit positions
`define CFG_SHADOW_BIT 0
`define CFG_ROMRW_BIT  1
`define CFG_NMI_BIT    3
`define CFG_BRK_BIT    4

// paging control bits
`define P7FFD_LOCK_BIT    5 // 48k lock, only in 1-meg block mode
`define PEFF7_BLOCK1M_BIT 2 // 1 = pentagon-1024 extension off

// values after reset
`define CFG_RESET    8'h00
`define P7FFD_RESET  8'h00
`define PEFF7_RESET  8'h00
`define BORDER_RESET 4'h0

`endif

//--- logic/zport_pkg.sv
// shared types of the I/O port block
// compile first, before any port module
`default_nettype none

package zport_pkg;

	// z80 bus as sampled by the port block
	typedef struct packed {
		logic [15:0] a;      // full port address
		logic [7:0]  din;    // cpu write data
		logic        iorq_n;
		logic        rd_n;
		logic        wr_n;
	} zbus_t;

	// one fclk pulse at the start of an I/O cycle
	typedef struct packed {
		logic wr;
		logic rd;
	} io_strobe_t;

	// paging state as seen by the memory mapper
	typedef struct packed {
		logic [7:0] p7ffd;      // masked in 1-meg block mode
		logic [7:0] peff7;      // masked in 1-meg block mode
		logic [5:0] page;       // full 1-meg ram page
		logic       rom;        // 7FFD bit 4
		logic       one_meg_on; // pentagon-1024 extension active
		logic       ram0_0;     // ram page 0 at 0000
	} paging_t;

	// port chosen by the current address
	typedef enum logic [3:0] {
		PSEL_NONE,
		PSEL_FE,       // FE and F6
		PSEL_FD,       // FD and FC
		PSEL_EFF7,
		PSEL_F7_OTHER, // every other xxF7
		PSEL_KJOY,
		PSEL_KMOUSE,
		PSEL_BF,
		PSEL_ULAPLUS
	} port_sel_e;

endpackage

`default_nettype wire

//--- logic/io_strobe.sv
// detects the start of z80 I/O cycles in the fclk domain
// bus is sampled on zpos, one pulse per read or write cycle
`timescale 1ns/100ps
`default_nettype none

module io_strobe
(
	input  wire                    fclk,
	input  wire                    rst_n,
	input  wire                    zpos, // z80 clock rising edge enable
	input  zport_pkg::zbus_t       bus,
	output zport_pkg::io_strobe_t  strb
);

	logic [1:0] iowr_h; // [0] zpos sample, [1] same delayed by one fclk
	logic [1:0] iord_h;

	logic iowr_act;
	logic iord_act;

	assign iowr_act = ~(bus.iorq_n | bus.wr_n);
	assign iord_act = ~(bus.iorq_n | bus.rd_n);

	//////////////////////////////////////////////////////////////////////
	// history of cycle activity

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			iowr_h <= 2'b00;
			iord_h <= 2'b00;
		end
		else
		begin
			if (zpos)
			begin
				iowr_h[0] <= iowr_act;
				iord_h[0] <= iord_act;
			end
			iowr_h[1] <= iowr_h[0]; // every fclk, so a long cycle gives one edge
			iord_h[1] <= iord_h[0];
		end
	end

	// rising edge of the sampled activity
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			strb <= '0;
		else
		begin
			strb.wr <= iowr_h[0] & ~iowr_h[1];
			strb.rd <= iord_h[0] & ~iord_h[1];
		end
	end

	// z80 never reads and writes in one cycle
	a_no_rdwr: assert property (@(posedge fclk) disable iff (!rst_n)
		!(strb.wr && strb.rd));

endmodule

`default_nettype wire

//--- logic/port_decode.sv
// port address decode, port hit and read-back data
// purely combinational, select is shared with every register block
`timescale 1ns/100ps
`default_nettype none

`include "zport_consts.svh"

module port_decode
(
	input  zport_pkg::zbus_t      bus,
	input  wire                   shadow,
	input  wire [4:0]             keys_in,   // keyboard columns
	input  wire                   tape_read,
	input  wire [4:0]             kj_in,     // kempston joystick
	input  wire [7:0]             mus_in,    // mouse byte
	input  wire [7:0]             cfg_rd,    // xxBF read-back
	input  wire [7:0]             up_lastwritten,
	output zport_pkg::port_sel_e  sel,
	output logic                  porthit,
	output logic                  dataout,
	output logic [7:0]            dout
);

	import zport_pkg::*;

	logic [7:0] lo;

	assign lo = bus.a[7:0];

	//////////////////////////////////////////////////////////////////////
	// address to port select

	always_comb
	begin
		case (lo)
			`PORT_FE, `PORT_F6:
				sel = PSEL_FE;
			`PORT_FD, `PORT_FC: // FC also loads border, sys_config checks it
				sel = PSEL_FD;
			`PORT_F7:
				if (bus.a[8] && !bus.a[12] && !shadow)
					sel = PSEL_EFF7;
				else
					sel = PSEL_F7_OTHER; // no clock behind it, reads FF
			`PORT_KJOY:
				sel = shadow ? PSEL_NONE : PSEL_KJOY; // 1F is the fdc under dos
			`PORT_KMOUSE:
				sel = PSEL_KMOUSE;
			`PORT_BF:
				sel = PSEL_BF;
			`PORT_ULAPLUS:
				sel = PSEL_ULAPLUS;
			default:
				sel = PSEL_NONE;
		endcase
	end

	assign porthit = (sel != PSEL_NONE);
	assign dataout = porthit & ~bus.iorq_n & ~bus.rd_n; // drive z80 data bus

	// read data
	always_comb
	begin
		case (sel)
			PSEL_FE:      dout = {1'b1, tape_read, 1'b0, keys_in};
			PSEL_KJOY:    dout = {3'b000, kj_in};
			PSEL_KMOUSE:  dout = mus_in;
			PSEL_BF:      dout = cfg_rd;
			PSEL_ULAPLUS: dout = up_lastwritten;
			default:      dout = 8'hFF; // FD, F7 and others float high
		endcase
	end

endmodule

`default_nettype wire

//--- logic/sys_config.sv
// xxBF config register with shadow, and the FE border/beeper port
// writes land one fclk after the write strobe
`timescale 1ns/100ps
`default_nettype none

`include "zport_consts.svh"

module sys_config
(
	input  wire                    fclk,
	input  wire                    rst_n,
	input  zport_pkg::zbus_t       bus,
	input  zport_pkg::io_strobe_t  strb,
	input  zport_pkg::port_sel_e   sel,
	input  wire                    dos,       // trdos rom active
	output logic                   shadow,
	output logic [7:0]             cfg_rd,
	output logic                   romrw_en,  // rom write enable
	output logic                   set_nmi,
	output logic                   brk_ena,
	output logic [3:0]             border,
	output logic                   beeper_wr
);

	import zport_pkg::*;

	// only the implemented xxBF bits are stored
	localparam logic [7:0] CFG_WMASK = (8'd1 << `CFG_SHADOW_BIT) | (8'd1 << `CFG_ROMRW_BIT) |
		(8'd1 << `CFG_NMI_BIT) | (8'd1 << `CFG_BRK_BIT);

	logic [7:0] cfg_q;
	logic       cfg_wr;
	logic       border_wr;

	//////////////////////////////////////////////////////////////////////
	// xxBF

	assign cfg_wr = strb.wr && (sel == PSEL_BF);

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			cfg_q <= `CFG_RESET;
		else if (cfg_wr)
			cfg_q <= bus.din & CFG_WMASK;
	end

	assign cfg_rd   = cfg_q; // unused bits read as 0
	assign shadow   = dos | cfg_q[`CFG_SHADOW_BIT];
	assign romrw_en = cfg_q[`CFG_ROMRW_BIT];
	assign set_nmi  = cfg_q[`CFG_NMI_BIT];
	assign brk_ena  = cfg_q[`CFG_BRK_BIT];

	//////////////////////////////////////////////////////////////////////
	// border, FE/F6 plus FC

	assign border_wr = strb.wr &&
		((sel == PSEL_FE) || ((sel == PSEL_FD) && (bus.a[7:0] == `PORT_FC)));

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			border <= `BORDER_RESET;
		else if (border_wr)
			border <= {~bus.a[3], bus.din[2:0]}; // bright from inverted a3
	end

	// beeper only on exact FE, not the mirrors
	assign beeper_wr = strb.wr && (sel == PSEL_FE) && (bus.a[7:0] == `PORT_FE);

endmodule

`default_nettype wire

//--- logic/mem_paging.sv
// pentagon-1024 paging, 7FFD and EFF7 ports
// block1m in EFF7 falls back to plain 128k with the 48k lock
`timescale 1ns/100ps
`default_nettype none

`include "zport_consts.svh"

module mem_paging
(
	input  wire                    fclk,
	input  wire                    rst_n,
	input  zport_pkg::zbus_t       bus,
	input  zport_pkg::io_strobe_t  strb,
	input  zport_pkg::port_sel_e   sel,
	output zport_pkg::paging_t     paging
);

	import zport_pkg::*;

	logic [7:0] p7ffd_q; // 2..0 page, 3 screen, 4 rom, 5 lock, 7..6 high page
	logic [7:0] peff7_q; // 2 block1m, 3 ram0 at 0000
	logic       block1m;
	logic       lock;
	logic       p7ffd_wr;
	logic       peff7_wr;

	assign block1m = peff7_q[`PEFF7_BLOCK1M_BIT];
	assign lock    = p7ffd_q[`P7FFD_LOCK_BIT] & block1m;

	// xxFD with a15 low, BFFD/FFFD belong to the ay
	assign p7ffd_wr = strb.wr && (sel == PSEL_FD) && !bus.a[15] && !lock;
	assign peff7_wr = strb.wr && (sel == PSEL_EFF7);

	//////////////////////////////////////////////////////////////////////
	// registers

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			p7ffd_q <= `P7FFD_RESET;
		else if (p7ffd_wr)
			p7ffd_q <= bus.din;
	end

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			peff7_q <= `PEFF7_RESET;
		else if (peff7_wr)
			peff7_q <= bus.din;
	end

	//////////////////////////////////////////////////////////////////////
	// outputs

	assign paging.p7ffd = {(block1m ? 3'b000 : p7ffd_q[7:5]), p7ffd_q[4:0]};
	assign paging.peff7 = block1m ?
		{peff7_q[7], 1'b0, peff7_q[5:4], 3'b000, peff7_q[0]} : peff7_q;
	assign paging.page       = {p7ffd_q[7:5], p7ffd_q[2:0]};
	assign paging.rom        = p7ffd_q[4];
	assign paging.one_meg_on = ~peff7_q[`PEFF7_BLOCK1M_BIT];
	assign paging.ram0_0     = peff7_q[3];

	// 48k lock holds until reset, whatever the cpu writes
	a_lock_hold: assert property (@(posedge fclk) disable iff (!rst_n)
		lock |=> $stable(p7ffd_q));

endmodule

`default_nettype wire

//--- logic/ulaplus_regs.sv
// ulaplus port, mode select and palette write strobe
// a14 low selects group/address, a14 high carries data
`timescale 1ns/100ps
`default_nettype none

`include "zport_consts.svh"

module ulaplus_regs
(
	input  wire                    fclk,
	input  wire                    rst_n,
	input  zport_pkg::zbus_t       bus,
	input  zport_pkg::io_strobe_t  strb,
	input  zport_pkg::port_sel_e   sel,
	output logic                   up_ena,
	output logic [5:0]             up_paladdr,
	output logic [7:0]             up_paldata,
	output logic                   up_palwr,
	output logic [7:0]             up_lastwritten
);

	import zport_pkg::*;

	logic up_wr;
	logic up_select; // 1 mode group, 0 palette

	assign up_wr = strb.wr && (sel == PSEL_ULAPLUS);

	//////////////////////////////////////////////////////////////////////
	// select/address writes

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			up_select <= 1'b0;
		else if (up_wr && !bus.a[14])
		begin
			if (bus.din[7:6] == 2'b01)
				up_select <= 1'b1;
			else if (bus.din[7:6] == 2'b00)
				up_select <= 1'b0;
		end
	end

	// palette address, loaded by a select write with top bits 00
	always_ff @(posedge fclk)
	begin
		if (up_wr && !bus.a[14] && (bus.din[7:6] == 2'b00))
			up_paladdr <= bus.din[5:0];
	end

	//////////////////////////////////////////////////////////////////////
	// data writes

	always_ff @(posedge fclk)
	begin
		if (up_wr && bus.a[14])
			up_lastwritten <= bus.din; // read back on 3B
	end

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			up_ena <= 1'b0;
		else if (up_wr && bus.a[14] && up_select)
			up_ena <= bus.din[0];
	end

	assign up_palwr   = up_wr && bus.a[14] && !up_select;
	assign up_paldata = {bus.din[4:2], bus.din[7:5], bus.din[1:0]}; // grb to rgb order

endmodule

`default_nettype wire

//--- logic/zports.sv
// I/O port block top, z80 pins in, register state out
// everything runs on fclk, bus sampled with zpos
`timescale 1ns/100ps
`default_nettype none

module zports
(
	input  wire                 fclk,
	input  wire                 rst_n,
	input  wire                 zpos,
	input  wire [15:0]          a,
	input  wire [7:0]           din,
	input  wire                 iorq_n,
	input  wire                 rd_n,
	input  wire                 wr_n,
	input  wire                 dos,
	input  wire [4:0]           keys_in,
	input  wire                 tape_read,
	input  wire [4:0]           kj_in,
	input  wire [7:0]           mus_in,
	output logic                porthit,   // to zxbus iorq gating
	output logic                dataout,
	output logic [7:0]          dout,
	output logic [3:0]          border,
	output logic                beeper_wr,
	output logic                romrw_en,
	output logic                set_nmi,
	output logic                brk_ena,
	output zport_pkg::paging_t  paging,
	output logic                up_ena,
	output logic [5:0]          up_paladdr,
	output logic [7:0]          up_paldata,
	output logic                up_palwr
);

	import zport_pkg::*;

	zbus_t      bus;
	io_strobe_t strb;
	port_sel_e  sel;
	logic       shadow;
	logic [7:0] cfg_rd;
	logic [7:0] up_lastwritten;

	assign bus = '{a: a, din: din, iorq_n: iorq_n, rd_n: rd_n, wr_n: wr_n};

	io_strobe io_strobe_i (.fclk(fclk), .rst_n(rst_n), .zpos(zpos), .bus(bus), .strb(strb));

	port_decode port_decode_i (
		.bus(bus), .shadow(shadow), .keys_in(keys_in), .tape_read(tape_read),
		.kj_in(kj_in), .mus_in(mus_in), .cfg_rd(cfg_rd), .up_lastwritten(up_lastwritten),
		.sel(sel), .porthit(porthit), .dataout(dataout), .dout(dout));

	sys_config sys_config_i (
		.fclk(fclk), .rst_n(rst_n), .bus(bus), .strb(strb), .sel(sel), .dos(dos),
		.shadow(shadow), .cfg_rd(cfg_rd), .romrw_en(romrw_en), .set_nmi(set_nmi),
		.brk_ena(brk_ena), .border(border), .beeper_wr(beeper_wr));

	mem_paging mem_paging_i (
		.fclk(fclk), .rst_n(rst_n), .bus(bus), .strb(strb), .sel(sel), .paging(paging));

	ulaplus_regs ulaplus_regs_i (
		.fclk(fclk), .rst_n(rst_n), .bus(bus), .strb(strb), .sel(sel),
		.up_ena(up_ena), .up_paladdr(up_paladdr), .up_paldata(up_paldata),
		.up_palwr(up_palwr), .up_lastwritten(up_lastwritten));

endmodule

`default_nettype wire

//--- tests/zports_tb.sv
// testbench for the I/O port block, runs a table of bus cycles through zports
// each row is one z80 I/O read or write, checked against its expected values
`timescale 1ns/100ps
`default_nettype none

`include "zport_consts.svh"

module zports_tb;

	import zport_pkg::*;

	// row kinds
	localparam logic [2:0] K_READ   = 3'd0; // porthit, dataout, dout
	localparam logic [2:0] K_CFG    = 3'd1; // xxBF output bits
	localparam logic [2:0] K_BORDER = 3'd2; // exp[3:0] border, exp[7:4] beeper pulses
	localparam logic [2:0] K_PAGING = 3'd3; // exp[24:0] paging struct
	localparam logic [2:0] K_ULA    = 3'd4; // exp[0] up_ena
	localparam logic [2:0] K_PADDR  = 3'd5; // exp[7:0] palette address
	localparam logic [2:0] K_PAL    = 3'd6; // exp[7:0] palette data, exp[11:8] pulses

	// where read data comes from
	localparam logic [1:0] S_LIT   = 2'd0;
	localparam logic [1:0] S_KEYS  = 2'd1;
	localparam logic [1:0] S_JOY   = 2'd2;
	localparam logic [1:0] S_MOUSE = 2'd3;

	typedef struct packed {
		logic        wr;   // 1 write, 0 read
		logic [15:0] addr;
		logic [7:0]  data;
		logic        dos;
		logic [2:0]  kind;
		logic [31:0] exp;
	} row_t;

	logic        fclk;
	logic        rst_n;
	logic [1:0]  zph = 2'd0; // zpos phase
	wire         zpos;
	logic [15:0] a;
	logic [7:0]  din;
	logic        iorq_n, rd_n, wr_n;
	logic        dos;
	logic [4:0]  keys_in;
	logic        tape_read;
	logic [4:0]  kj_in;
	logic [7:0]  mus_in;
	logic        porthit, dataout;
	logic [7:0]  dout;
	logic [3:0]  border;
	logic        beeper_wr, romrw_en, set_nmi, brk_ena;
	paging_t     paging;
	logic        up_ena;
	logic [5:0]  up_paladdr;
	logic [7:0]  up_paldata;
	logic        up_palwr;

	row_t        rows[$];
	integer      seed;
	logic [31:0] rnd;
	int          cyc = 0;
	int          limit = 0;  // set once the table is built
	int          beeps = 0;
	int          palwrs = 0;
	logic [7:0]  pal_seen = 8'h00; // paldata at the last palwr pulse

	zports dut_i (
		.fclk(fclk), .rst_n(rst_n), .zpos(zpos), .a(a), .din(din), .iorq_n(iorq_n),
		.rd_n(rd_n), .wr_n(wr_n), .dos(dos), .keys_in(keys_in), .tape_read(tape_read),
		.kj_in(kj_in), .mus_in(mus_in), .porthit(porthit), .dataout(dataout), .dout(dout),
		.border(border), .beeper_wr(beeper_wr), .romrw_en(romrw_en), .set_nmi(set_nmi),
		.brk_ena(brk_ena), .paging(paging), .up_ena(up_ena), .up_paladdr(up_paladdr),
		.up_paldata(up_paldata), .up_palwr(up_palwr));

	//////////////////////////////////////////////////////////////////////
	// clock, zpos, pulse counters, timeout

	initial
	begin
		fclk = 1'b0;
		forever #20 fclk = ~fclk; // 40 ns
	end

	assign zpos = (zph == 2'd3); // one fclk in four
	always @(negedge fclk)
		zph <= zph + 2'd1;

	// strobes are sampled mid-cycle
	always @(negedge fclk)
	begin
		if (beeper_wr)
			beeps <= beeps + 1;
		if (up_palwr)
		begin
			palwrs   <= palwrs + 1;
			pal_seen <= up_paldata;
		end
	end

	always @(posedge fclk)
	begin
		cyc <= cyc + 1;
		if (limit > 0 && cyc > limit)
			stop_with_error($sformatf("run did not end within %0d clock cycles", limit));
	end

	//////////////////////////////////////////////////////////////////////
	// compare and table helpers

	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display("TEST FAIL");
		$fatal(1, "simulation stopped");
	endtask

	task automatic byte_match(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp)
			stop_with_error($sformatf("ERR %s: got %h expected %h", name, got, exp));
	endtask

	task automatic bit_match(input string name, input logic got, input logic exp);
		if (got !== exp)
			stop_with_error($sformatf("ERR %s: got %h expected %h", name, got, exp));
	endtask

	task automatic nibble_match(input string name, input logic [3:0] got, input logic [3:0] exp);
		if (got !== exp)
			stop_with_error($sformatf("ERR %s: got %h expected %h", name, got, exp));
	endtask

	task automatic paging_match(input paging_t got, input paging_t exp);
		if (got !== exp)
			stop_with_error($sformatf("ERR paging: got %h expected %h", got, exp));
	endtask

	function automatic logic [31:0] read_exp(input logic hit, input logic [1:0] src,
		input logic [7:0] val);
		return {21'd0, src, hit, val};
	endfunction

	function automatic paging_t pg_exp(input logic [7:0] p7, input logic [7:0] pe,
		input logic [5:0] page, input logic rom, input logic onem, input logic ram0);
		return '{p7ffd: p7, peff7: pe, page: page, rom: rom, one_meg_on: onem, ram0_0: ram0};
	endfunction

	task add_row(input logic wr, input logic [15:0] addr, input logic [7:0] data,
		input logic dos_v, input logic [2:0] kind, input logic [31:0] exp);
		rows.push_back('{wr: wr, addr: addr, data: data, dos: dos_v, kind: kind, exp: exp});
	endtask

	//////////////////////////////////////////////////////////////////////
	// one bus cycle, 8 fclk active then 8 idle

	task run_row(input row_t r);
		logic [7:0] want;
		int         b0;
		int         p0;
		int         d;
		a   = r.addr;
		din = r.data;
		dos = r.dos;
		rnd = $random(seed);
		keys_in   = rnd[4:0];
		kj_in     = rnd[9:5];
		tape_read = rnd[10];
		mus_in    = rnd[18:11];
		b0 = beeps;
		p0 = palwrs;
		@(negedge fclk);
		iorq_n = 1'b0;
		rd_n   = r.wr;
		wr_n   = ~r.wr;
		repeat (4) @(negedge fclk);
		if (r.kind == K_READ)
		begin
			case (r.exp[10:9])
				S_KEYS:  want = {1'b1, tape_read, 1'b0, keys_in}; // FE layout
				S_JOY:   want = {3'b000, kj_in};
				S_MOUSE: want = mus_in;
				default: want = r.exp[7:0];
			endcase
			bit_match("porthit", porthit, r.exp[8]);
			bit_match("dataout", dataout, r.exp[8]); // read is active here
			byte_match("dout", dout, want);
		end
		else
			bit_match("dataout", dataout, 1'b0); // writes never drive the bus
		repeat (4) @(negedge fclk);
		iorq_n = 1'b1;
		rd_n   = 1'b1;
		wr_n   = 1'b1;
		repeat (8) @(negedge fclk);
		case (r.kind)
			K_CFG:
			begin
				bit_match("romrw_en", romrw_en, r.exp[`CFG_ROMRW_BIT]);
				bit_match("set_nmi", set_nmi, r.exp[`CFG_NMI_BIT]);
				bit_match("brk_ena", brk_ena, r.exp[`CFG_BRK_BIT]);
			end
			K_BORDER:
			begin
				d = beeps - b0;
				nibble_match("border", border, r.exp[3:0]);
				nibble_match("beeper_wr pulses", d[3:0], r.exp[7:4]);
			end
			K_PAGING:
				paging_match(paging, paging_t'(r.exp[24:0]));
			K_ULA:
				bit_match("up_ena", up_ena, r.exp[0]);
			K_PADDR:
			begin
				d = palwrs - p0;
				byte_match("up_paladdr", {2'b00, up_paladdr}, r.exp[7:0]);
				nibble_match("up_palwr pulses", d[3:0], 4'd0);
			end
			K_PAL:
			begin
				d = palwrs - p0;
				nibble_match("up_palwr pulses", d[3:0], r.exp[11:8]);
				byte_match("up_paldata", pal_seen, r.exp[7:0]);
			end
			default: ;
		endcase
	endtask

	//////////////////////////////////////////////////////////////////////
	// table and main sequence

	initial
	begin
		seed = 32'ha1a2_30cb;
		rst_n = 1'b0;
		a = 16'h0000;
		din = 8'h00;
		iorq_n = 1'b1;
		rd_n = 1'b1;
		wr_n = 1'b1;
		dos = 1'b0;
		keys_in = 5'd0;
		tape_read = 1'b0;
		kj_in = 5'd0;
		mus_in = 8'h00;

		// reads, shadow off then dos on
		add_row(1'b0, {8'h00, `PORT_FE}, 8'h00, 1'b0, K_READ, read_exp(1'b1, S_KEYS, 8'h00));
		add_row(1'b0, {8'h00, `PORT_KMOUSE}, 8'h00, 1'b0, K_READ, read_exp(1'b1, S_MOUSE, 8'h00));
		add_row(1'b0, {8'h00, `PORT_KJOY}, 8'h00, 1'b0, K_READ, read_exp(1'b1, S_JOY, 8'h00));
		add_row(1'b0, {8'h00, `PORT_BF}, 8'h00, 1'b0, K_READ, read_exp(1'b1, S_LIT, 8'h00));
		add_row(1'b0, {8'h00, `PORT_F7}, 8'h00, 1'b0, K_READ, read_exp(1'b1, S_LIT, 8'hFF));
		add_row(1'b0, 16'h0055, 8'h00, 1'b0, K_READ, read_exp(1'b0, S_LIT, 8'hFF)); // unused
		add_row(1'b0, {8'h00, `PORT_KJOY}, 8'h00, 1'b1, K_READ, read_exp(1'b0, S_LIT, 8'hFF));
		add_row(1'b0, {8'h00, `PORT_FE}, 8'h00, 1'b1, K_READ, read_exp(1'b1, S_KEYS, 8'h00));
		add_row(1'b0, {8'h00, `PORT_KMOUSE}, 8'h00, 1'b1, K_READ, read_exp(1'b1, S_MOUSE, 8'h00));
		add_row(1'b0, {8'h00, `PORT_F7}, 8'h00, 1'b1, K_READ, read_exp(1'b1, S_LIT, 8'hFF));
		// xxBF, bits 1 3 4 then shadow enable alone
		add_row(1'b1, {8'h00, `PORT_BF}, 8'h1A, 1'b0, K_CFG, 32'h1A);
		add_row(1'b0, {8'h00, `PORT_BF}, 8'h00, 1'b0, K_READ, read_exp(1'b1, S_LIT, 8'h1A));
		add_row(1'b1, {8'h00, `PORT_BF}, 8'h01, 1'b0, K_CFG, 32'h01);
		add_row(1'b0, {8'h00, `PORT_KJOY}, 8'h00, 1'b0, K_READ, read_exp(1'b0, S_LIT, 8'hFF));
		add_row(1'b0, {8'h00, `PORT_BF}, 8'h00, 1'b0, K_READ, read_exp(1'b1, S_LIT, 8'h01));
		add_row(1'b1, {8'h00, `PORT_BF}, 8'h00, 1'b0, K_CFG, 32'h00);
		add_row(1'b0, {8'h00, `PORT_KJOY}, 8'h00, 1'b0, K_READ, read_exp(1'b1, S_JOY, 8'h00));
		// border, a3 set on FE and FC, clear on F6
		add_row(1'b1, {8'h00, `PORT_FE}, 8'h05, 1'b0, K_BORDER, 32'h15);
		add_row(1'b1, {8'h80, `PORT_FC}, 8'h03, 1'b0, K_BORDER, 32'h03); // a15 high, no paging
		add_row(1'b1, {8'h00, `PORT_F6}, 8'h02, 1'b0, K_BORDER, 32'h0A);
		// 7FFD
		add_row(1'b1, 16'h7FFD, 8'h13, 1'b0, K_PAGING,
			{7'd0, pg_exp(8'h13, 8'h00, 6'h03, 1'b1, 1'b1, 1'b0)});
		add_row(1'b1, 16'hFFFD, 8'h07, 1'b0, K_PAGING,
			{7'd0, pg_exp(8'h13, 8'h00, 6'h03, 1'b1, 1'b1, 1'b0)});
		add_row(1'b1, 16'h7FFD, 8'hC2, 1'b0, K_PAGING,
			{7'd0, pg_exp(8'hC2, 8'h00, 6'h32, 1'b0, 1'b1, 1'b0)});
		// EFF7 block1m, then the 48k lock
		add_row(1'b1, 16'hEFF7, 8'h0C, 1'b0, K_PAGING,
			{7'd0, pg_exp(8'h02, 8'h00, 6'h32, 1'b0, 1'b0, 1'b1)});
		add_row(1'b1, 16'h7FFD, 8'h25, 1'b0, K_PAGING, // bits 7..5 read as 0 in block1m
			{7'd0, pg_exp(8'h05, 8'h00, 6'h0D, 1'b0, 1'b0, 1'b1)});
		add_row(1'b1, 16'h7FFD, 8'h07, 1'b0, K_PAGING,
			{7'd0, pg_exp(8'h05, 8'h00, 6'h0D, 1'b0, 1'b0, 1'b1)});
		add_row(1'b1, 16'hEFF7, 8'h00, 1'b1, K_PAGING, // shadow hides EFF7
			{7'd0, pg_exp(8'h05, 8'h00, 6'h0D, 1'b0, 1'b0, 1'b1)});
		// ulaplus group, palette address, palette data, read-back
		add_row(1'b1, {8'hBF, `PORT_ULAPLUS}, 8'h40, 1'b0, K_ULA, 32'h0);
		add_row(1'b1, {8'hFF, `PORT_ULAPLUS}, 8'h01, 1'b0, K_ULA, 32'h1);
		add_row(1'b1, {8'hBF, `PORT_ULAPLUS}, 8'h15, 1'b0, K_PADDR, 32'h15);
		add_row(1'b1, {8'hFF, `PORT_ULAPLUS}, 8'hE3, 1'b0, K_PAL, 32'h11F); // 000_111_11
		add_row(1'b0, {8'hFF, `PORT_ULAPLUS}, 8'h00, 1'b0, K_READ, read_exp(1'b1, S_LIT, 8'hE3));

		limit = rows.size() * 20 + 16 + 100; // rows, reset, margin

		repeat (16) @(negedge fclk);
		rst_n = 1'b1;
		repeat (2) @(negedge fclk);
		foreach (rows[i])
			run_row(rows[i]);
		$display("TEST PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- project.f
+incdir+include
logic/zport_pkg.sv
logic/io_strobe.sv
logic/port_decode.sv
logic/sys_config.sv
logic/mem_paging.sv
logic/ulaplus_regs.sv
logic/zports.sv
tests/zports_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the port block testbench with Verilator and run it
# exit status is nonzero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert --timescale 1ns/100ps \
	--top-module zports_tb -Mdir obj_dir -f project.f; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Vzports_tb
status=$?
if [ "$status" -ne 0 ]; then
	echo "simulation failed with status $status"
	exit "$status"
fi

exit 0
